// File: bpPkg.sv
`default_nettype none

package bpPkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int AddrWidth = 32;                      // processor address width

    typedef logic [AddrWidth-1:0] addrT;                // byte address
    typedef logic [AddrWidth-3:0] targetT;              // word address, bits 31..2

    ////////////////////
    // branch types
    ////////////////////

    typedef logic [1:0] brTypeT;                        // branch type code

    localparam brTypeT BrNone = 2'b00;                  // not a branch
    localparam brTypeT BrCond = 2'b01;                  // conditional
    localparam brTypeT BrJump = 2'b10;                  // unconditional jump
    localparam brTypeT BrCall = 2'b11;                  // call, predicted like a jump

    ////////////////////
    // pattern entry
    ////////////////////

    typedef logic [1:0] historyT;                       // last two outcomes, newest in bit 0
    typedef logic [1:0] counterT;                       // saturating, msb means taken

    // entry layout, high to low:
    //   [9:8] history
    //   [7:6] counter for history 11
    //   [5:4] counter for history 10
    //   [3:2] counter for history 01
    //   [1:0] counter for history 00
    typedef logic [9:0] patternT;

endpackage

`default_nettype wire

// File: slotIf.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////
// build side write
////////////////////

interface slotWriteIf #(
    parameter int PairIndexBits = 5
);
    localparam int TagBits = bpPkg::AddrWidth - PairIndexBits - 3;  // bits above index

    logic                     wrEn;                     // slot write strobe
    logic [PairIndexBits-1:0] index;                    // pair index
    logic [TagBits-1:0]       tag;                      // pair tag
    bpPkg::targetT            target;                   // word target
    bpPkg::brTypeT            brType;                   // branch type

    modport tableSide (output wrEn, index, tag, target, brType);
    modport slot      (input  wrEn, index, tag, target, brType);
endinterface

////////////////////
// fetch side lookup
////////////////////

interface slotReadIf #(
    parameter int PairIndexBits = 5
);
    localparam int TagBits = bpPkg::AddrWidth - PairIndexBits - 3;

    logic [PairIndexBits-1:0] index;                    // lookup index
    logic [TagBits-1:0]       tag;                      // lookup tag
    logic                     hit;                      // valid and tag match
    bpPkg::targetT            target;                   // zero on miss
    bpPkg::brTypeT            brType;                   // zero on miss

    modport tableSide (output index, tag, input  hit, target, brType);
    modport slot      (input  index, tag, output hit, target, brType);
endinterface

`default_nettype wire

// File: targetSlot.sv
`timescale 1ns/1ps
`default_nettype none

module targetSlot #(
    parameter int PairIndexBits = 5
)(
    input  wire logic clk,
    input  wire logic rstn,
    slotWriteIf.slot  wr,                               // build write port
    slotReadIf.slot   rd                                // fetch lookup port
);
    localparam int Depth   = 1 << PairIndexBits;
    localparam int TagBits = bpPkg::AddrWidth - PairIndexBits - 3;

    logic [Depth-1:0]   valid;                          // one bit per pair index
    logic [TagBits-1:0] tagMem [Depth];                 // stored tags
    bpPkg::targetT      targetMem [Depth];              // stored word targets
    bpPkg::brTypeT      typeMem [Depth];                // stored branch types

    logic rdValid;                                      // valid at lookup index
    logic tagMatch;                                     // stored tag equals lookup tag

    ////////////////////
    // write side
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;                                // all slots empty
        end else if (wr.wrEn) begin
            valid[wr.index] <= 1'b1;                    // mark written slot
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wrEn) begin
            tagMem[wr.index]    <= wr.tag;
            targetMem[wr.index] <= wr.target;
            typeMem[wr.index]   <= wr.brType;
        end
    end

    ////////////////////
    // lookup side
    ////////////////////

    assign rdValid   = valid[rd.index];
    assign tagMatch  = tagMem[rd.index] == rd.tag;
    assign rd.hit    = rdValid && tagMatch;             // old contents on same-cycle write
    assign rd.target = rd.hit ? targetMem[rd.index] : '0;
    assign rd.brType = rd.hit ? typeMem[rd.index] : bpPkg::BrNone;

    // a lookup that holds still only starts hitting after a write to its index
    hitNeedsWrite: assert property (@(posedge clk) disable iff (!rstn)
        $rose(rd.hit) && $stable(rd.index) && $stable(rd.tag)
        |-> $past(wr.wrEn) && $past(wr.index) == rd.index);

    wrEnKnown: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(wr.wrEn));

endmodule

`default_nettype wire

// File: pairTargetTable.sv
`timescale 1ns/1ps
`default_nettype none

module pairTargetTable #(
    parameter int PairIndexBits = 5
)(
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          idEn,                    // build strobe
    input  wire bpPkg::addrT   idPC,                    // pair being built
    input  wire logic          idUsefulLower,           // write lower slot
    input  wire logic          idUsefulUpper,           // write upper slot
    input  wire bpPkg::brTypeT idTypeLower,
    input  wire bpPkg::brTypeT idTypeUpper,
    input  wire bpPkg::addrT   idTargetLower,
    input  wire bpPkg::addrT   idTargetUpper,
    input  wire bpPkg::addrT   ifPC,                    // fetch pair
    output      logic          ifHitLower,
    output      logic          ifHitUpper,
    output      bpPkg::addrT   ifTargetLower,           // low two bits zero
    output      bpPkg::addrT   ifTargetUpper,
    output      bpPkg::brTypeT ifTypeLower,
    output      bpPkg::brTypeT ifTypeUpper
);
    localparam int AW = bpPkg::AddrWidth;

    slotWriteIf #(.PairIndexBits(PairIndexBits)) wrLower();
    slotWriteIf #(.PairIndexBits(PairIndexBits)) wrUpper();
    slotReadIf  #(.PairIndexBits(PairIndexBits)) rdLower();
    slotReadIf  #(.PairIndexBits(PairIndexBits)) rdUpper();

    ////////////////////
    // build split
    ////////////////////

    assign wrLower.wrEn   = idEn & idUsefulLower;       // skipped slot keeps contents
    assign wrLower.index  = idPC[PairIndexBits+2:3];
    assign wrLower.tag    = idPC[AW-1:PairIndexBits+3];
    assign wrLower.target = idTargetLower[AW-1:2];      // drop byte offset
    assign wrLower.brType = idTypeLower;

    assign wrUpper.wrEn   = idEn & idUsefulUpper;
    assign wrUpper.index  = idPC[PairIndexBits+2:3];    // same pair index and tag
    assign wrUpper.tag    = idPC[AW-1:PairIndexBits+3];
    assign wrUpper.target = idTargetUpper[AW-1:2];
    assign wrUpper.brType = idTypeUpper;

    ////////////////////
    // fetch split
    ////////////////////

    assign rdLower.index = ifPC[PairIndexBits+2:3];
    assign rdLower.tag   = ifPC[AW-1:PairIndexBits+3];
    assign rdUpper.index = ifPC[PairIndexBits+2:3];
    assign rdUpper.tag   = ifPC[AW-1:PairIndexBits+3];

    targetSlot #(.PairIndexBits(PairIndexBits)) slotLower (.clk, .rstn, .wr(wrLower), .rd(rdLower));
    targetSlot #(.PairIndexBits(PairIndexBits)) slotUpper (.clk, .rstn, .wr(wrUpper), .rd(rdUpper));

    assign ifHitLower    = rdLower.hit;
    assign ifHitUpper    = rdUpper.hit;
    assign ifTargetLower = {rdLower.target, 2'b00};     // back to byte address
    assign ifTargetUpper = {rdUpper.target, 2'b00};
    assign ifTypeLower   = rdLower.brType;
    assign ifTypeUpper   = rdUpper.brType;

endmodule

`default_nettype wire

// File: historyInit.sv
`timescale 1ns/1ps
`default_nettype none

module historyInit (
    input  wire bpPkg::brTypeT brType,                  // resolved branch type
    input  wire logic          back,                    // target below pc
    input  wire logic          taken,                   // resolved outcome
    output      bpPkg::patternT entry                   // first pattern entry
);
    always_comb begin
        case (brType)
            bpPkg::BrJump,
            bpPkg::BrCall: begin
                entry = '1;                             // always taken
            end
            bpPkg::BrCond: begin
                if (back) begin
                    entry = {back, taken, 8'b10_10_10_01};  // loops lean taken
                end else begin
                    entry = {back, taken, 8'b10_01_01_01};  // forward leans not taken
                end
            end
            default: begin
                entry = '0;                             // never taken
            end
        endcase
    end

endmodule

`default_nettype wire

// File: historyUpdate.sv
`timescale 1ns/1ps
`default_nettype none

module historyUpdate (
    input  wire bpPkg::patternT old,                    // stored entry
    input  wire logic           taken,                  // resolved outcome
    output      bpPkg::patternT entry                   // trained entry
);
    bpPkg::historyT hist;                               // old history
    bpPkg::counterT count;                              // selected counter
    bpPkg::counterT nextCount;                          // after training
    logic [2:0]     base;                               // counter lsb position

    assign hist = old[9:8];
    assign base = {hist, 1'b0};                         // 2 * history
    assign count = old[base +: 2];

    ////////////////////
    // counter training
    ////////////////////

    always_comb begin
        if (taken) begin
            if (count == 2'b11) begin
                nextCount = count;                      // saturate high
            end else begin
                nextCount = count + 2'd1;
            end
        end else begin
            if (count == 2'b00) begin
                nextCount = count;                      // saturate low
            end else begin
                nextCount = count - 2'd1;
            end
        end
    end

    ////////////////////
    // entry rebuild
    ////////////////////

    always_comb begin
        entry             = old;                        // other counters unchanged
        entry[9:8]        = {hist[0], taken};           // shift in newest outcome
        entry[base +: 2]  = nextCount;
    end

endmodule

`default_nettype wire

// File: patternTable.sv
`timescale 1ns/1ps
`default_nettype none

module patternTable #(
    parameter int PatternIndexBits = 6
)(
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          bdEn,                    // resolve strobe
    input  wire bpPkg::addrT   bdPC,                    // resolved instruction
    input  wire bpPkg::addrT   bdTarget,                // its branch target
    input  wire bpPkg::brTypeT bdType,
    input  wire logic          bdTaken,                 // actual outcome
    input  wire bpPkg::addrT   ifPC,                    // fetch pair
    output      logic          ifTakenLower,
    output      logic          ifTakenUpper
);
    localparam int Depth = 1 << PatternIndexBits;
    localparam int AW    = bpPkg::AddrWidth;

    logic [Depth-1:0] valid;                            // one bit per instruction
    bpPkg::patternT   patMem [Depth];                   // pattern entries

    logic [PatternIndexBits-1:0] bdIndex;
    logic [PatternIndexBits-1:0] ifIndexLower;
    logic [PatternIndexBits-1:0] ifIndexUpper;

    logic           bdBack;                             // backward branch
    bpPkg::patternT initEntry;                          // first-seen entry
    bpPkg::patternT updEntry;                           // trained stored entry
    bpPkg::patternT wrEntry;                            // value written on bdEn

    // taken when the counter picked by the history has its msb set
    function automatic logic predict(input bpPkg::patternT e);
        bpPkg::historyT h;
        h = e[9:8];
        return e[{h, 1'b1}];                            // bit 2*h+1
    endfunction

    ////////////////////
    // resolve path
    ////////////////////

    assign bdIndex = bdPC[PatternIndexBits+1:2];
    assign bdBack  = bdTarget[AW-1:2] < bdPC[AW-1:2];   // word compare

    historyInit uInit (
        .brType (bdType),
        .back   (bdBack),
        .taken  (bdTaken),
        .entry  (initEntry)
    );

    historyUpdate uUpdate (
        .old    (patMem[bdIndex]),
        .taken  (bdTaken),
        .entry  (updEntry)
    );

    assign wrEntry = valid[bdIndex] ? updEntry : initEntry;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (bdEn) begin
            valid[bdIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bdEn) begin
            patMem[bdIndex] <= wrEntry;                 // read-modify-write
        end
    end

    ////////////////////
    // fetch path
    ////////////////////

    assign ifIndexLower = {ifPC[PatternIndexBits+1:3], 1'b0};
    assign ifIndexUpper = {ifPC[PatternIndexBits+1:3], 1'b1};

    assign ifTakenLower = valid[ifIndexLower] && predict(patMem[ifIndexLower]);
    assign ifTakenUpper = valid[ifIndexUpper] && predict(patMem[ifIndexUpper]);

    // an unknown outcome would poison the counters for good
    bdTakenKnown: assert property (@(posedge clk) disable iff (!rstn)
        bdEn |-> !$isunknown(bdTaken));

endmodule

`default_nettype wire

// File: bpTop.sv
`timescale 1ns/1ps
`default_nettype none

module bpTop #(
    parameter int PairIndexBits    = 5,                 // pair table depth 2^n
    parameter int PatternIndexBits = 6                  // pattern table depth 2^n
)(
    input  wire logic          clk,
    input  wire logic          rstn,

    // build
    input  wire logic          idEn,
    input  wire bpPkg::addrT   idPC,
    input  wire logic          idUsefulLower,
    input  wire logic          idUsefulUpper,
    input  wire bpPkg::brTypeT idTypeLower,
    input  wire bpPkg::brTypeT idTypeUpper,
    input  wire bpPkg::addrT   idTargetLower,
    input  wire bpPkg::addrT   idTargetUpper,

    // resolve
    input  wire logic          bdEn,
    input  wire bpPkg::addrT   bdPC,
    input  wire bpPkg::addrT   bdTarget,
    input  wire bpPkg::brTypeT bdType,
    input  wire logic          bdTaken,

    // fetch
    input  wire bpPkg::addrT   ifPC,
    output      logic          ifHitLower,
    output      logic          ifHitUpper,
    output      bpPkg::addrT   ifTargetLower,
    output      bpPkg::addrT   ifTargetUpper,
    output      bpPkg::brTypeT ifTypeLower,
    output      bpPkg::brTypeT ifTypeUpper,
    output      logic          ifTakenLower,
    output      logic          ifTakenUpper
);

    pairTargetTable #(.PairIndexBits(PairIndexBits)) uPairTable (
        .clk, .rstn,
        .idEn, .idPC, .idUsefulLower, .idUsefulUpper,
        .idTypeLower, .idTypeUpper, .idTargetLower, .idTargetUpper,
        .ifPC,
        .ifHitLower, .ifHitUpper, .ifTargetLower, .ifTargetUpper,
        .ifTypeLower, .ifTypeUpper
    );

    patternTable #(.PatternIndexBits(PatternIndexBits)) uPatternTable (
        .clk, .rstn,
        .bdEn, .bdPC, .bdTarget, .bdType, .bdTaken,
        .ifPC,
        .ifTakenLower, .ifTakenUpper
    );

endmodule

`default_nettype wire

// File: tbBpTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbBpTop;
    localparam int PairIdxBits = 5;
    localparam int PatIdxBits  = 6;
    localparam int PairDepth   = 1 << PairIdxBits;
    localparam int PatDepth    = 1 << PatIdxBits;
    localparam int TagLo       = PairIdxBits + 3;       // lowest tag bit
    localparam int ResetCycles = 10;
    localparam int TestCycles  = 21 + 9 + 4 + 15 + 121;  // tests 1..5
    localparam int TimeoutCycles = 2 * TestCycles + ResetCycles;

    logic clk, rstn, idEn, idUsefulLower, idUsefulUpper, bdEn, bdTaken;
    bpPkg::addrT   idPC, idTargetLower, idTargetUpper, bdPC, bdTarget, ifPC;
    bpPkg::brTypeT idTypeLower, idTypeUpper, bdType;
    logic          ifHitLower, ifHitUpper, ifTakenLower, ifTakenUpper;
    bpPkg::addrT   ifTargetLower, ifTargetUpper;
    bpPkg::brTypeT ifTypeLower, ifTypeUpper;

    // reference tables per slot with 0 lower and 1 upper
    logic           ptValid [2][PairDepth];
    bpPkg::addrT    ptTag [2][PairDepth];
    bpPkg::addrT    ptTarget [2][PairDepth];
    bpPkg::brTypeT  ptType [2][PairDepth];
    logic           patValid [PatDepth];
    bpPkg::patternT pat [PatDepth];

    logic          expHit [2], expTaken [2];
    bpPkg::addrT   expTarget [2];
    bpPkg::brTypeT expType [2];
    int            li, pi, mi, cycleCount, errCount, checkCount, errBase;
    int            testNum, testsPassed, testsFailed;
    logic          checkOn, modelBack;
    bpPkg::addrT   lcgState, r, pcA, pcSet [6];

    bpTop #(.PairIndexBits(PairIdxBits), .PatternIndexBits(PatIdxBits)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                          // 8 ns period
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic int pairIndex(bpPkg::addrT pc);
        return int'((pc >> 3) & bpPkg::addrT'(PairDepth - 1));
    endfunction

    function automatic int patIndex(bpPkg::addrT pc);
        return int'((pc >> 2) & bpPkg::addrT'(PatDepth - 1));   // one entry per word
    endfunction

    function automatic bpPkg::patternT initEntry(bpPkg::brTypeT t, logic back, logic taken);
        if (t == bpPkg::BrJump || t == bpPkg::BrCall)
            return 10'h3ff;                             // strongly taken everywhere
        if (t != bpPkg::BrCond)
            return 10'h000;
        if (back)
            return {back, taken, 2'b10, 2'b10, 2'b10, 2'b01};
        return {back, taken, 2'b10, 2'b01, 2'b01, 2'b01};
    endfunction

    function automatic bpPkg::patternT trainEntry(bpPkg::patternT old, logic taken);
        bpPkg::counterT c [4];
        int h;
        for (int i = 0; i < 4; i++)
            c[i] = old[2*i +: 2];
        h = int'(old[9:8]);
        if (taken && c[h] != 2'b11)
            c[h] = c[h] + 2'b01;
        else if (!taken && c[h] != 2'b00)
            c[h] = c[h] - 2'b01;
        return {old[8], taken, c[3], c[2], c[1], c[0]};   // history shifts left
    endfunction

    function automatic logic predictTaken(bpPkg::patternT e);
        bpPkg::counterT c;
        c = e[2*int'(e[9:8]) +: 2];
        return c[1];
    endfunction

    task automatic storeSlot(int s, bpPkg::addrT pc, bpPkg::brTypeT t, bpPkg::addrT tgt);
        ptValid[s][pairIndex(pc)]  = 1'b1;
        ptTag[s][pairIndex(pc)]    = pc >> TagLo;
        ptTarget[s][pairIndex(pc)] = tgt & ~32'h3;      // word aligned
        ptType[s][pairIndex(pc)]   = t;
    endtask

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < PairDepth; i++) begin
                ptValid[0][i] = 1'b0;
                ptValid[1][i] = 1'b0;
            end
            for (int i = 0; i < PatDepth; i++)
                patValid[i] = 1'b0;
        end else begin
            if (idEn && idUsefulLower) storeSlot(0, idPC, idTypeLower, idTargetLower);
            if (idEn && idUsefulUpper) storeSlot(1, idPC, idTypeUpper, idTargetUpper);
            if (bdEn) begin
                mi = patIndex(bdPC);
                modelBack = (bdTarget >> 2) < (bdPC >> 2);
                pat[mi] = patValid[mi] ? trainEntry(pat[mi], bdTaken)
                                       : initEntry(bdType, modelBack, bdTaken);
                patValid[mi] = 1'b1;
            end
        end
    end

    ////////////////////
    // checker
    ////////////////////

    task automatic compareField(string name, bpPkg::addrT exp, bpPkg::addrT act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("FAILED %s expected %h got %h (ifPC %h)", name, exp, act, ifPC);
        end
    endtask

    always @(negedge clk) begin
        if (checkOn) begin
            #2;                                         // after stimulus settles
            li = pairIndex(ifPC);
            for (int s = 0; s < 2; s++) begin
                expHit[s]    = ptValid[s][li] && ptTag[s][li] == (ifPC >> TagLo);
                expTarget[s] = expHit[s] ? ptTarget[s][li] : '0;
                expType[s]   = expHit[s] ? ptType[s][li] : bpPkg::BrNone;
                pi = patIndex({ifPC[31:3], s[0], 2'b00});
                expTaken[s]  = patValid[pi] && predictTaken(pat[pi]);
            end
            compareField("ifHitLower", 32'(expHit[0]), 32'(ifHitLower));
            compareField("ifHitUpper", 32'(expHit[1]), 32'(ifHitUpper));
            compareField("ifTargetLower", expTarget[0], ifTargetLower);
            compareField("ifTargetUpper", expTarget[1], ifTargetUpper);
            compareField("ifTypeLower", 32'(expType[0]), 32'(ifTypeLower));
            compareField("ifTypeUpper", 32'(expType[1]), 32'(ifTypeUpper));
            compareField("ifTakenLower", 32'(expTaken[0]), 32'(ifTakenLower));
            compareField("ifTakenUpper", 32'(expTaken[1]), 32'(ifTakenUpper));
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycleCount);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////

    function automatic bpPkg::addrT nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic idleCycle();
        @(negedge clk);
        idEn = 1'b0;
        bdEn = 1'b0;
    endtask

    task automatic lookupPair(bpPkg::addrT pc);
        idleCycle();
        ifPC = pc;
    endtask

    task automatic buildPair(bpPkg::addrT pc, logic ul, logic uu,
                             bpPkg::brTypeT tl, bpPkg::brTypeT tu);
        lookupPair(pc);                                 // same-cycle lookup sees old entry
        idEn = 1'b1;
        idPC = pc;
        idUsefulLower = ul;
        idUsefulUpper = uu;
        idTypeLower = tl;
        idTypeUpper = tu;
        idTargetLower = nextRand();
        idTargetUpper = nextRand();                     // random low bits get dropped
    endtask

    task automatic resolveBranch(bpPkg::addrT pc, bpPkg::addrT tgt, bpPkg::brTypeT t,
                                 logic taken, bpPkg::addrT look);
        lookupPair(look);
        bdEn = 1'b1;
        bdPC = pc;
        bdTarget = tgt;
        bdType = t;
        bdTaken = taken;
    endtask

    task automatic closeTest(string name);
        idleCycle();
        #3;                                             // last check done
        testNum++;
        if (errCount == errBase) begin
            testsPassed++;
            $display("test %0d %s: ok", testNum, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d errors", testNum, name, errCount - errBase);
        end
        errBase = errCount;
    endtask

    initial begin
        {rstn, idEn, idUsefulLower, idUsefulUpper, bdEn, bdTaken, checkOn} = '0;
        {idPC, idTargetLower, idTargetUpper, bdPC, bdTarget, ifPC} = '0;
        {idTypeLower, idTypeUpper, bdType} = '0;
        {errCount, checkCount, errBase, testNum, testsPassed, testsFailed} = '0;
        lcgState = 32'd59;
        repeat (ResetCycles) @(posedge clk);
        checkOn = 1'b1;
        @(negedge clk);
        rstn = 1'b1;

        repeat (20) lookupPair(nextRand());             // empty tables
        closeTest("lookups after reset");

        pcA = 32'h0000_1040;
        buildPair(pcA, 1'b1, 1'b0, bpPkg::BrCond, bpPkg::BrJump);
        lookupPair(pcA);
        lookupPair(pcA + 32'h4);
        lookupPair(pcA ^ 32'h0001_0000);                // same index with another tag
        buildPair(32'h0000_2088, 1'b1, 1'b1, bpPkg::BrCall, bpPkg::BrCond);
        lookupPair(32'h0000_208c);
        buildPair(32'h0000_20f0, 1'b0, 1'b1, bpPkg::BrJump, bpPkg::BrCond);
        lookupPair(32'h0000_20f0);
        closeTest("build and hit");

        buildPair(pcA + 32'h100, 1'b1, 1'b1, bpPkg::BrJump, bpPkg::BrCall);
        lookupPair(pcA);                                // replaced so it misses
        lookupPair(pcA + 32'h100);
        closeTest("rebuild new tag");

        resolveBranch(32'h400, 32'h200, bpPkg::BrCond, 1'b1, 32'h400);   // backward
        lookupPair(32'h400);
        resolveBranch(32'h504, 32'h600, bpPkg::BrCond, 1'b0, 32'h500);   // forward
        lookupPair(32'h500);
        repeat (3) begin
            resolveBranch(32'h608, 32'h700, bpPkg::BrJump, 1'b1, 32'h608);
            lookupPair(32'h608);
        end
        repeat (2) begin
            resolveBranch(32'h60c, 32'h610, bpPkg::BrNone, 1'b0, 32'h608);
            lookupPair(32'h60c);
        end
        closeTest("first resolve");

        // neighbours in one pair plus two aliases of the pattern index
        pcSet = '{32'h3000, 32'h3004, 32'h3008, 32'h300c, 32'h3100, 32'h3104};
        repeat (60) begin
            r = nextRand();
            pcA = pcSet[int'(r[20:16]) % 6];
            resolveBranch(pcA, r[21] ? pcA - 32'h40 : pcA + 32'h40,
                          r[23:22] != 2'b00 ? bpPkg::BrCond : r[25:24],
                          r[26], pcSet[int'(r[31:27]) % 6]);
            lookupPair(pcA);
        end
        closeTest("random resolves");

        $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                 testsPassed, testsFailed, checkCount, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
bpPkg.sv
slotIf.sv
targetSlot.sv
pairTargetTable.sv
historyInit.sv
historyUpdate.sv
patternTable.sv
bpTop.sv
tbBpTop.sv

// File: run.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbBpTop -f tb.f -o simv
./obj_dir/simv | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
